// File: Makefile
# Verilator build and run of the AXI-Lite bus testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_soc_bus \
		-f tb.f -Mdir obj_dir -o Vtb_soc_bus

run: compile
	-./obj_dir/Vtb_soc_bus > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Everything OK" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: src/axil_bus_router.sv
`timescale 1ns/1ps

module axil_bus_router import soc_pkg::*; #(
	parameter addr_t BOOT_BASE  = soc_pkg::BOOT_BASE,
	parameter addr_t MAIN_BASE  = soc_pkg::MAIN_BASE,
	parameter int    BOOT_WORDS = 8192,
	parameter int    MAIN_WORDS = 1024
) (
	input  logic  hdmi_pixClk,
	input  logic  rst_n,

	input  addr_t s_awaddr,
	input  logic  s_awvalid,
	output logic  s_awready,
	input  data_t s_wdata,
	input  strb_t s_wstrb,
	input  logic  s_wvalid,
	output logic  s_wready,
	output resp_t s_bresp,
	output logic  s_bvalid,
	input  logic  s_bready,
	input  addr_t s_araddr,
	input  logic  s_arvalid,
	output logic  s_arready,
	output data_t s_rdata,
	output resp_t s_rresp,
	output logic  s_rvalid,
	input  logic  s_rready,

	mem_if.ctrl   boot,
	mem_if.ctrl   main
);

	localparam int BOOT_AW = idx_bits(BOOT_WORDS);
	localparam int MAIN_AW = idx_bits(MAIN_WORDS);

	router_state_t state;

	logic  phase_q;      // Second cycle of ST_ACCESS
	logic  boot_req_q;
	logic  main_req_q;
	logic  wr_q;
	logic  boot_hit_q;
	logic  main_hit_q;
	addr_t addr_q;
	data_t wdata_q;
	strb_t wstrb_q;

	logic  wr_accept;
	logic  rd_accept;
	addr_t req_addr;
	logic  boot_sel;
	logic  main_sel;
	addr_t boot_off;
	addr_t main_off;
	logic  hit_q;
	logic  ack_any;
	data_t rdata_mux;
	logic  resp_due;
	logic  resp_taken;
	resp_t resp_code;

	// Base and size check; an address below base wraps and misses
	function automatic logic in_window(addr_t a, addr_t base, int unsigned words);
		addr_t off;
		off = a - base;
		return off < addr_t'(words * BYTES_PER_WORD);
	endfunction

	// Write needs both channels; a read waits while any write channel is valid
	assign wr_accept = (state == ST_IDLE) && s_awvalid && s_wvalid;
	assign rd_accept = (state == ST_IDLE) && s_arvalid && !s_awvalid && !s_wvalid;

	assign s_awready = wr_accept;
	assign s_wready  = wr_accept;
	assign s_arready = rd_accept;

	assign req_addr = wr_accept ? s_awaddr : s_araddr;
	assign boot_sel = in_window(req_addr, BOOT_BASE, BOOT_WORDS);
	assign main_sel = !boot_sel && in_window(req_addr, MAIN_BASE, MAIN_WORDS);

	// Region requests
	assign boot_off   = addr_q - BOOT_BASE;
	assign main_off   = addr_q - MAIN_BASE;

	assign boot.req   = boot_req_q;
	assign boot.we    = wr_q;
	assign boot.addr  = boot_off[BOOT_AW+1:2];
	assign boot.wdata = wdata_q;
	assign boot.wstrb = wstrb_q;

	assign main.req   = main_req_q;
	assign main.we    = wr_q;
	assign main.addr  = main_off[MAIN_AW+1:2];
	assign main.wdata = wdata_q;
	assign main.wstrb = wstrb_q;

	// Completion; a miss just waits out the same two cycles
	assign hit_q     = boot_hit_q | main_hit_q;
	assign ack_any   = boot.ack | main.ack;
	assign rdata_mux = boot.ack ? boot.rdata : (main.ack ? main.rdata : '0);
	assign resp_due  = hit_q ? ack_any : phase_q;
	assign resp_code = hit_q ? RESP_OKAY : RESP_DECERR;

	assign resp_taken = (s_bvalid && s_bready) || (s_rvalid && s_rready);

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			phase_q    <= 1'b0;
			boot_req_q <= 1'b0;
			main_req_q <= 1'b0;
			s_bvalid   <= 1'b0;
			s_rvalid   <= 1'b0;
		end else begin
			boot_req_q <= 1'b0;
			main_req_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wr_accept || rd_accept) begin
						state      <= ST_ACCESS;
						phase_q    <= 1'b0;
						boot_req_q <= boot_sel;
						main_req_q <= main_sel;
					end
				end
				ST_ACCESS: begin
					phase_q <= 1'b1;
					if (resp_due) begin
						state <= ST_RESP;
						if (wr_q)
							s_bvalid <= 1'b1;
						else
							s_rvalid <= 1'b1;
					end
				end
				ST_RESP: begin
					// Hold until the master takes it
					if (resp_taken) begin
						state    <= ST_IDLE;
						s_bvalid <= 1'b0;
						s_rvalid <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Accepted transaction and response payload
	always_ff @(posedge hdmi_pixClk) begin
		if (wr_accept || rd_accept) begin
			wr_q       <= wr_accept;
			addr_q     <= req_addr;
			wdata_q    <= s_wdata;
			wstrb_q    <= s_wstrb;
			boot_hit_q <= boot_sel;
			main_hit_q <= main_sel;
		end
		if (state == ST_ACCESS && resp_due) begin
			if (wr_q) begin
				s_bresp <= resp_code;
			end else begin
				s_rresp <= resp_code;
				s_rdata <= rdata_mux; // Zero on a miss
			end
		end
	end

endmodule

// File: src/axil_word_ram.sv
`timescale 1ns/1ps

module axil_word_ram import soc_pkg::*; #(
	parameter int WORDS = 1024
) (
	input logic hdmi_pixClk,
	mem_if.mem  bus
);

	localparam int LANES = $bits(strb_t);

	data_t mem [WORDS];
	data_t merged;

	// Stored word with the strobed lanes replaced
	always_comb begin
		merged = mem[bus.addr];
		for (int b = 0; b < LANES; b++) begin
			if (bus.wstrb[b]) begin
				merged[8*b +: 8] = bus.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		bus.ack <= bus.req; // Fixed one-cycle latency
		if (bus.req) begin
			if (bus.we) begin
				mem[bus.addr] <= merged;
				bus.rdata     <= merged; // Read returns the new word
			end else begin
				bus.rdata <= mem[bus.addr];
			end
		end
	end

endmodule

// File: src/mem_if.sv
`timescale 1ns/1ps

interface mem_if import soc_pkg::*; #(
	parameter int WORDS = 1024
) ();

	localparam int AW = idx_bits(WORDS);

	logic          req;   // One-cycle request pulse
	logic          we;
	logic [AW-1:0] addr;  // Word index within the region
	data_t         wdata;
	strb_t         wstrb;
	data_t         rdata; // Valid while ack is high
	logic          ack;   // Exactly one cycle after req

	modport ctrl (
		output req,
		output we,
		output addr,
		output wdata,
		output wstrb,
		input  rdata,
		input  ack
	);

	modport mem (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		input  wstrb,
		output rdata,
		output ack
	);

endinterface

// File: src/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_pkg::*; #(
	parameter addr_t BOOT_BASE  = soc_pkg::BOOT_BASE,
	parameter addr_t MAIN_BASE  = soc_pkg::MAIN_BASE,
	parameter int    BOOT_WORDS = 8192,
	parameter int    MAIN_WORDS = 1024
) (
	input  logic  hdmi_pixClk,
	input  logic  rst_n,

	// AXI-Lite slave port
	input  addr_t s_awaddr,
	input  logic  s_awvalid,
	output logic  s_awready,
	input  data_t s_wdata,
	input  strb_t s_wstrb,
	input  logic  s_wvalid,
	output logic  s_wready,
	output resp_t s_bresp,
	output logic  s_bvalid,
	input  logic  s_bready,
	input  addr_t s_araddr,
	input  logic  s_arvalid,
	output logic  s_arready,
	output data_t s_rdata,
	output resp_t s_rresp,
	output logic  s_rvalid,
	input  logic  s_rready
);

	mem_if #(.WORDS(BOOT_WORDS)) boot_bus ();
	mem_if #(.WORDS(MAIN_WORDS)) main_bus ();

	axil_bus_router #(
		.BOOT_BASE (BOOT_BASE),
		.MAIN_BASE (MAIN_BASE),
		.BOOT_WORDS(BOOT_WORDS),
		.MAIN_WORDS(MAIN_WORDS)
	) i_router (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n      (rst_n),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_araddr   (s_araddr),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.boot       (boot_bus),
		.main       (main_bus)
	);

	// Bootloader RAM
	axil_word_ram #(
		.WORDS(BOOT_WORDS)
	) i_boot_ram (
		.hdmi_pixClk(hdmi_pixClk),
		.bus        (boot_bus)
	);

	// Main RAM, stands in for the SDRAM
	axil_word_ram #(
		.WORDS(MAIN_WORDS)
	) i_main_ram (
		.hdmi_pixClk(hdmi_pixClk),
		.bus        (main_bus)
	);

endmodule

// File: src/soc_pkg.sv
package soc_pkg;

	// Bus word types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// Address map
	localparam addr_t BOOT_BASE = 32'h0201_0000; // Bootloader RAM, 15-bit window
	localparam addr_t MAIN_BASE = 32'h0;         // Main RAM in place of the SDRAM

	localparam int BYTES_PER_WORD = 4;

	// Router transaction sequence
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_RESP
	} router_state_t;

	// Width of a word index for a region of the given size
	function automatic int idx_bits(int words);
		int bits;
		bits = 1;
		if (words > 1) begin
			bits = $clog2(words);
		end
		return bits;
	endfunction

endpackage

// File: tb.f
src/soc_pkg.sv
src/mem_if.sv
src/axil_bus_router.sv
src/axil_word_ram.sv
src/soc_bus_top.sv
testbench/axil_bus_router_props.sv
testbench/tb_soc_bus.sv

// File: testbench/axil_bus_router_props.sv
`timescale 1ns/1ps

module axil_bus_router_props import soc_pkg::*; (
	input logic          hdmi_pixClk,
	input logic          rst_n,
	input router_state_t state,
	input logic          s_awready,
	input logic          s_arready,
	input logic          s_bvalid,
	input logic          s_bready,
	input resp_t         s_bresp,
	input logic          s_rvalid,
	input logic          s_rready,
	input resp_t         s_rresp,
	input data_t         s_rdata,
	input logic          boot_req,
	input logic          main_req
);

	// Valid rises on the second edge after acceptance, seen one sample later
	a_write_latency: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		s_awready |-> ##3 s_bvalid)
		else $error("write response missing two cycles after acceptance");

	a_read_latency: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		s_arready |-> ##3 s_rvalid)
		else $error("read response missing two cycles after acceptance");

	a_b_hold: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bresp)))
		else $error("write response changed before bready");

	a_r_hold: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_rresp) && $stable(s_rdata)))
		else $error("read response changed before rready");

	// Region requests only leave from idle
	a_req_from_idle: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(boot_req || main_req) |-> ($past(state) == ST_IDLE))
		else $error("region request raised outside idle");

	a_one_region: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		!(boot_req && main_req))
		else $error("both regions requested at once");

endmodule

// File: testbench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus import soc_pkg::*; ();

	localparam int    CLK_PERIOD = 40;
	localparam addr_t BOOT_LO    = 32'h0201_0000;
	localparam addr_t MAIN_LO    = 32'h0000_0000;
	localparam int    BOOT_WORDS = 8192;
	localparam int    MAIN_WORDS = 1024;
	localparam addr_t BOOT_SPAN  = BOOT_WORDS * 4;
	localparam addr_t MAIN_SPAN  = MAIN_WORDS * 4;

	localparam int N_FULL    = 40;
	localparam int N_PART    = 40;
	localparam int N_MISS    = 20;
	localparam int N_RECHECK = 10;
	localparam int N_PAIR    = 10;
	localparam int NUM_TXN   = 2*N_FULL + 2*N_PART + 2*N_MISS + N_RECHECK + 5*N_PAIR;
	localparam int MAX_WAIT  = 16; // Cycles before a handshake counts as lost

	logic  hdmi_pixClk = 1'b0;
	logic  rst_n       = 1'b0;
	addr_t s_awaddr    = '0;
	logic  s_awvalid   = 1'b0;
	logic  s_awready;
	data_t s_wdata     = '0;
	strb_t s_wstrb     = '0;
	logic  s_wvalid    = 1'b0;
	logic  s_wready;
	resp_t s_bresp;
	logic  s_bvalid;
	logic  s_bready    = 1'b0;
	addr_t s_araddr    = '0;
	logic  s_arvalid   = 1'b0;
	logic  s_arready;
	data_t s_rdata;
	resp_t s_rresp;
	logic  s_rvalid;
	logic  s_rready    = 1'b0;

	integer seed = 32'h272f_0308;

	data_t model_mem [addr_t]; // Reference words by byte address
	addr_t filled_q [$];       // Words that hold known data

	always #(CLK_PERIOD/2) hdmi_pixClk = ~hdmi_pixClk;

	soc_bus_top #(
		.BOOT_BASE (BOOT_LO),
		.MAIN_BASE (MAIN_LO),
		.BOOT_WORDS(BOOT_WORDS),
		.MAIN_WORDS(MAIN_WORDS)
	) i_soc_bus_top (.*);

	bind axil_bus_router axil_bus_router_props i_props (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n      (rst_n),
		.state      (state),
		.s_awready  (s_awready),
		.s_arready  (s_arready),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_bresp    (s_bresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.s_rresp    (s_rresp),
		.s_rdata    (s_rdata),
		.boot_req   (boot_req_q),
		.main_req   (main_req_q)
	);

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic addr_t pick_boot();
		return BOOT_LO + addr_t'(rand_below(BOOT_WORDS) * 4);
	endfunction

	function automatic addr_t pick_main();
		return MAIN_LO + addr_t'(rand_below(MAIN_WORDS) * 4);
	endfunction

	function automatic logic in_map(addr_t a);
		return ((a >= BOOT_LO) && (a - BOOT_LO < BOOT_SPAN)) || (a - MAIN_LO < MAIN_SPAN);
	endfunction

	// Random words outside both windows, often just past an edge
	function automatic addr_t pick_miss();
		addr_t a;
		do begin
			case (rand_below(4))
				0: a = addr_t'($random(seed)) & 32'hffff_fffc;
				1: a = BOOT_LO + BOOT_SPAN + addr_t'(rand_below(16) * 4);
				2: a = BOOT_LO - 4 - addr_t'(rand_below(16) * 4);
				default: a = MAIN_LO + MAIN_SPAN + addr_t'(rand_below(16) * 4);
			endcase
		end while (in_map(a));
		return a;
	endfunction

	function automatic void model_write(addr_t a, data_t d, strb_t s);
		data_t w;
		if (in_map(a)) begin
			w = model_mem.exists(a) ? model_mem[a] : '0;
			for (int b = 0; b < 4; b++) begin
				if (s[b])
					w[8*b +: 8] = d[8*b +: 8];
			end
			model_mem[a] = w;
		end
	endfunction

	function automatic data_t model_read(addr_t a);
		if (in_map(a) && model_mem.exists(a))
			return model_mem[a];
		return '0;
	endfunction

	task automatic fail_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_quiet();
		check_eq(32'({s_awready, s_wready, s_arready, s_bvalid, s_rvalid}), 32'd0,
			"handshake outputs active before any request");
	endtask

	task automatic take_write_resp(output resp_t resp);
		int lat;
		int hold;
		lat = 0;
		@(negedge hdmi_pixClk);
		while (!s_bvalid) begin
			lat++;
			if (lat > MAX_WAIT) begin
				$display("Write response never arrived");
				fail_run();
			end
			@(negedge hdmi_pixClk);
		end
		check_eq(32'(lat), 32'd2, "write response latency");
		resp = s_bresp;
		hold = rand_below(6);
		repeat (hold) begin
			@(negedge hdmi_pixClk);
			check_eq(32'(s_bvalid), 32'd1, "bvalid dropped under back-pressure");
			check_eq(32'(s_bresp), 32'(resp), "bresp changed under back-pressure");
		end
		@(posedge hdmi_pixClk);
		s_bready <= 1'b1;
		@(negedge hdmi_pixClk);
		check_eq(32'(s_bvalid), 32'd1, "bvalid dropped before bready");
		check_eq(32'(s_bresp), 32'(resp), "bresp changed before bready");
		@(posedge hdmi_pixClk);
		s_bready <= 1'b0; // Handshake on this edge
		@(negedge hdmi_pixClk);
		check_eq(32'(s_bvalid), 32'd0, "bvalid held after handshake");
	endtask

	task automatic take_read_resp(output data_t data, output resp_t resp);
		int lat;
		int hold;
		lat = 0;
		@(negedge hdmi_pixClk);
		while (!s_rvalid) begin
			lat++;
			if (lat > MAX_WAIT) begin
				$display("Read response never arrived");
				fail_run();
			end
			@(negedge hdmi_pixClk);
		end
		check_eq(32'(lat), 32'd2, "read response latency");
		resp = s_rresp;
		data = s_rdata;
		hold = rand_below(6);
		repeat (hold) begin
			@(negedge hdmi_pixClk);
			check_eq(32'(s_rvalid), 32'd1, "rvalid dropped under back-pressure");
			check_eq(32'(s_rresp), 32'(resp), "rresp changed under back-pressure");
			check_eq(s_rdata, data, "rdata changed under back-pressure");
		end
		@(posedge hdmi_pixClk);
		s_rready <= 1'b1;
		@(negedge hdmi_pixClk);
		check_eq(32'(s_rvalid), 32'd1, "rvalid dropped before rready");
		check_eq(32'(s_rresp), 32'(resp), "rresp changed before rready");
		check_eq(s_rdata, data, "rdata changed before rready");
		@(posedge hdmi_pixClk);
		s_rready <= 1'b0;
		@(negedge hdmi_pixClk);
		check_eq(32'(s_rvalid), 32'd0, "rvalid held after handshake");
	endtask

	task automatic bus_write(input addr_t a, input data_t d, input strb_t s, output resp_t resp);
		int n;
		@(posedge hdmi_pixClk);
		s_awaddr  <= a;
		s_wdata   <= d;
		s_wstrb   <= s;
		s_awvalid <= 1'b1;
		s_wvalid  <= 1'b1;
		n = 0;
		@(negedge hdmi_pixClk);
		while (!(s_awready && s_wready)) begin
			n++;
			if (n > MAX_WAIT) begin
				$display("Write to %h was never accepted", a);
				fail_run();
			end
			@(negedge hdmi_pixClk);
		end
		@(posedge hdmi_pixClk);
		s_awvalid <= 1'b0;
		s_wvalid  <= 1'b0;
		take_write_resp(resp);
	endtask

	task automatic bus_read(input addr_t a, output data_t d, output resp_t resp);
		int n;
		@(posedge hdmi_pixClk);
		s_araddr  <= a;
		s_arvalid <= 1'b1;
		n = 0;
		@(negedge hdmi_pixClk);
		while (!s_arready) begin
			n++;
			if (n > MAX_WAIT) begin
				$display("Read from %h was never accepted", a);
				fail_run();
			end
			@(negedge hdmi_pixClk);
		end
		@(posedge hdmi_pixClk);
		s_arvalid <= 1'b0;
		take_read_resp(d, resp);
	endtask

	// Write, then read back against the model
	task automatic write_and_verify(input addr_t a, input data_t d, input strb_t s);
		resp_t r;
		data_t rd;
		if (in_map(a) && !model_mem.exists(a))
			filled_q.push_back(a);
		bus_write(a, d, s, r);
		model_write(a, d, s);
		check_eq(32'(r), 32'(in_map(a) ? RESP_OKAY : RESP_DECERR),
			$sformatf("write response at %h", a));
		bus_read(a, rd, r);
		check_eq(32'(r), 32'(in_map(a) ? RESP_OKAY : RESP_DECERR),
			$sformatf("read response at %h", a));
		check_eq(rd, model_read(a), $sformatf("read data at %h", a));
	endtask

	initial begin
		addr_t a;
		data_t d;
		int    idx;

		repeat (4) @(posedge hdmi_pixClk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge hdmi_pixClk);
			check_quiet();
		end

		for (int i = 0; i < N_FULL; i++) begin
			a = (i % 2 == 0) ? pick_boot() : pick_main();
			write_and_verify(a, $random(seed), 4'hf);
		end

		// Partial strobes only on words already filled
		for (int i = 0; i < N_PART; i++) begin
			a = filled_q[rand_below(filled_q.size())];
			write_and_verify(a, $random(seed), strb_t'(rand_below(15)));
		end

		for (int i = 0; i < N_MISS; i++) begin
			write_and_verify(pick_miss(), $random(seed), 4'hf);
		end
		for (int i = 0; i < N_RECHECK; i++) begin
			resp_t r;
			data_t rd;
			a = filled_q[rand_below(filled_q.size())];
			bus_read(a, rd, r);
			check_eq(32'(r), 32'(RESP_OKAY), $sformatf("recheck response at %h", a));
			check_eq(rd, model_read(a), $sformatf("recheck data at %h", a));
		end

		// Same word index in both regions
		for (int i = 0; i < N_PAIR; i++) begin
			resp_t r;
			data_t rd;
			idx = rand_below(MAIN_WORDS);
			d = $random(seed);
			a = BOOT_LO + addr_t'(idx * 4);
			write_and_verify(a, d, 4'hf);
			write_and_verify(MAIN_LO + addr_t'(idx * 4), ~d, 4'hf);
			bus_read(a, rd, r); // Boot word must survive the main write
			check_eq(32'(r), 32'(RESP_OKAY), $sformatf("pair response at %h", a));
			check_eq(rd, model_read(a), $sformatf("pair data at %h", a));
		end

		$display("Everything OK");
		$finish;
	end

	initial begin
		#(NUM_TXN * 20 * CLK_PERIOD);
		$display("Watchdog expired because the bus transactions did not finish in time");
		fail_run();
	end

endmodule
